// ==== hdl/bus_pkg.sv ====
// bus package
// widths of the cpu byte bus, register map and status bits

`default_nettype none

package bus_pkg;

    localparam int BUS_DATA_W = 8;              // cpu data bus is one byte
    localparam int REG_NUM_W  = 4;              // 2 bits channel, 2 bits register
    localparam int REG_DATA_W = 16;             // registers are whole words

    // low two bits of a register number, high two bits pick the channel
    localparam logic [1:0] REG_ADDR   = 2'd0;   // vram word address
    localparam logic [1:0] REG_INCR   = 2'd1;   // added to address after data access
    localparam logic [1:0] REG_DATA   = 2'd2;   // write data / prefetched read data
    localparam logic [1:0] REG_STATUS = 2'd3;   // busy and drop flags

    localparam int STATUS_BUSY_BIT = 0;         // request still pending
    localparam int STATUS_DROP_BIT = 1;         // data access lost, cleared by status write

endpackage

`default_nettype wire

// ==== hdl/vram_pkg.sv ====
// vram package
// memory size and channel count

`default_nettype none

package vram_pkg;

    localparam int NUM_CHAN    = 4;                     // access channels
    localparam int VRAM_DEPTH  = 1024;                  // words of video memory
    localparam int VRAM_ADDR_W = $clog2(VRAM_DEPTH);    // 10 bits
    localparam int CHAN_SEL_W  = $clog2(NUM_CHAN);      // 2 bits

endpackage

`default_nettype wire

// ==== hdl/bus_interface.sv ====
// cpu bus interface
// syncs the async byte bus, pairs even/odd bytes into register writes, serves reads

`default_nettype none
`timescale 1ns/1ps

module bus_interface (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             bus_cs_n_i,      // active low chip select
    input  logic                             bus_rd_nwr_i,    // high for read
    input  logic [bus_pkg::REG_NUM_W-1:0]    bus_reg_num_i,
    input  logic                             bus_bytesel_i,   // high for odd byte
    input  logic [bus_pkg::BUS_DATA_W-1:0]   bus_data_i,
    output logic [bus_pkg::BUS_DATA_W-1:0]   bus_data_o,
    output logic                             write_strobe_o,  // one cycle on odd byte write
    output logic                             read_strobe_o,   // one cycle on odd byte read
    output logic [bus_pkg::REG_NUM_W-1:0]    reg_num_o,
    output logic [bus_pkg::REG_DATA_W-1:0]   reg_data_o,      // word to write
    input  logic [bus_pkg::REG_DATA_W-1:0]   reg_data_i       // word read back
);
    import bus_pkg::*;

    // two flop syncs with bit 1 as first stage and bit 0 acted on
    logic [1:0]                  cs_s;          // select, active high
    logic                        cs_d;          // previous synced select
    logic [1:0]                  rd_s;
    logic [1:0]                  bsel_s;
    logic [1:0][REG_NUM_W-1:0]   num_s;
    logic [1:0][BUS_DATA_W-1:0]  data_s;

    // last values seen while selected and used once select goes away
    logic                        cap_rd;
    logic                        cap_bsel;
    logic [BUS_DATA_W-1:0]       cap_data;

    logic [REG_NUM_W-1:0]        even_num;      // register of buffered even byte
    logic [BUS_DATA_W-1:0]       even_data;     // buffered even byte for the high half
    logic                        cs_rise;

    assign cs_rise = cs_d && !cs_s[0];          // bus_cs_n_i went high

    always_ff @(posedge clk) begin
        rd_s   <= {bus_rd_nwr_i, rd_s[1]};
        bsel_s <= {bus_bytesel_i, bsel_s[1]};
        num_s  <= {bus_reg_num_i, num_s[1]};
        data_s <= {bus_data_i, data_s[1]};
        if (cs_s[0]) begin                      // track while selected
            cap_rd   <= rd_s[0];
            cap_bsel <= bsel_s[0];
            cap_data <= data_s[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_s           <= '0;
            cs_d           <= 1'b0;
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
            reg_num_o      <= '0;
            reg_data_o     <= '0;
            bus_data_o     <= '0;
            even_num       <= '0;
            even_data      <= '0;
        end else begin
            cs_s           <= {~bus_cs_n_i, cs_s[1]};
            cs_d           <= cs_s[0];
            write_strobe_o <= 1'b0;             // strobes default low
            read_strobe_o  <= 1'b0;

            if (cs_s[0]) begin
                reg_num_o <= num_s[0];          // also selects read-back word
                if (rd_s[0]) begin
                    bus_data_o <= bsel_s[0] ? reg_data_i[15:8] : reg_data_i[7:0];
                end
            end

            if (cs_rise) begin
                if (cap_rd) begin
                    read_strobe_o <= cap_bsel;  // odd byte ends the read
                end else if (cap_bsel) begin
                    write_strobe_o <= 1'b1;
                    // high byte only if the even byte went to the same register
                    reg_data_o <= {(reg_num_o == even_num) ? even_data : 8'h00, cap_data};
                end else begin
                    even_num  <= reg_num_o;     // hold even byte for the odd one
                    even_data <= cap_data;
                end
            end
        end
    end

    // strobes come three cycles after bus_cs_n_i rises
    a_strobe_timing: assert property (@(posedge clk) disable iff (reset_i)
        write_strobe_o || read_strobe_o |-> $past(bus_cs_n_i, 3) && !$past(bus_cs_n_i, 4));

endmodule

`default_nettype wire

// ==== hdl/vram_channel.sv ====
// vram access channel
// address, increment, write data and prefetch registers with one pending request

`default_nettype none
`timescale 1ns/1ps

module vram_channel #(
    parameter int CHAN_ID = 0                               // position in register map
) (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  logic                                  write_strobe_i,
    input  logic                                  read_strobe_i,
    input  logic [bus_pkg::REG_NUM_W-1:0]         reg_num_i,
    input  logic [bus_pkg::REG_DATA_W-1:0]        reg_data_i,
    input  logic                                  grant_i,
    input  logic                                  rdata_valid_i,
    input  logic [bus_pkg::REG_DATA_W-1:0]        rdata_i,
    output logic                                  req_o,    // held until grant
    output logic                                  req_we_o,
    output logic [vram_pkg::VRAM_ADDR_W-1:0]      req_addr_o,
    output logic [bus_pkg::REG_DATA_W-1:0]        req_wdata_o,
    output logic [3:0][bus_pkg::REG_DATA_W-1:0]   chan_reg_word_o
);
    import bus_pkg::*;
    import vram_pkg::*;

    logic [VRAM_ADDR_W-1:0]  addr_r;
    logic [VRAM_ADDR_W-1:0]  addr_next;
    logic [REG_DATA_W-1:0]   incr_r;        // full word kept for read-back
    logic [REG_DATA_W-1:0]   prefetch_r;    // word served on data reads
    logic                    rd_pending;    // granted read still waiting for data
    logic                    drop_r;
    logic                    busy;
    logic                    hit;           // channel field matches
    logic                    data_wr;       // accepted data write

    assign hit       = reg_num_i[REG_NUM_W-1 -: CHAN_SEL_W] == CHAN_SEL_W'(CHAN_ID);
    assign busy      = req_o || rd_pending;
    assign addr_next = addr_r + incr_r[VRAM_ADDR_W-1:0];    // wraps at VRAM_DEPTH
    assign data_wr   = write_strobe_i && hit && reg_num_i[1:0] == REG_DATA && !busy;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_o      <= 1'b0;
            req_we_o   <= 1'b0;
            req_addr_o <= '0;
            addr_r     <= '0;
            incr_r     <= '0;
            rd_pending <= 1'b0;
            drop_r     <= 1'b0;
        end else begin
            if (grant_i) begin
                req_o      <= 1'b0;
                rd_pending <= !req_we_o;            // reads wait for rdata_valid
            end else if (rdata_valid_i) begin
                rd_pending <= 1'b0;
            end

            if (write_strobe_i && hit) begin
                case (reg_num_i[1:0])
                    REG_ADDR: begin
                        addr_r <= reg_data_i[VRAM_ADDR_W-1:0];
                        if (busy) begin
                            drop_r <= 1'b1;         // prefetch lost
                        end else begin
                            req_o      <= 1'b1;
                            req_we_o   <= 1'b0;
                            req_addr_o <= reg_data_i[VRAM_ADDR_W-1:0];
                        end
                    end
                    REG_INCR: incr_r <= reg_data_i;
                    REG_DATA: begin
                        if (busy) begin
                            drop_r <= 1'b1;
                        end else begin
                            req_o      <= 1'b1;     // write at current address
                            req_we_o   <= 1'b1;
                            req_addr_o <= addr_r;
                            addr_r     <= addr_next;
                        end
                    end
                    default: drop_r <= 1'b0;        // status write clears drop
                endcase
            end

            if (read_strobe_i && hit && reg_num_i[1:0] == REG_DATA) begin
                if (busy) begin
                    drop_r <= 1'b1;
                end else begin
                    req_o      <= 1'b1;             // step and fetch ahead
                    req_we_o   <= 1'b0;
                    req_addr_o <= addr_next;
                    addr_r     <= addr_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            req_wdata_o <= reg_data_i;
        end
        if (reset_i) begin
            prefetch_r <= '0;
        end else if (rdata_valid_i) begin
            prefetch_r <= rdata_i;
        end
    end

    always_comb begin
        chan_reg_word_o                             = '0;
        chan_reg_word_o[REG_ADDR]                   = REG_DATA_W'(addr_r);
        chan_reg_word_o[REG_INCR]                   = incr_r;
        chan_reg_word_o[REG_DATA]                   = prefetch_r;
        chan_reg_word_o[REG_STATUS][STATUS_BUSY_BIT] = busy;
        chan_reg_word_o[REG_STATUS][STATUS_DROP_BIT] = drop_r;
    end

    // request fields must not move while the arbiter may pick them
    a_req_hold: assert property (@(posedge clk) disable iff (reset_i)
        req_o && !grant_i |=> req_o && $stable(req_we_o) && $stable(req_addr_o)
                              && $stable(req_wdata_o));

    a_rdata_owned: assert property (@(posedge clk) disable iff (reset_i)
        rdata_valid_i |-> rd_pending);

endmodule

`default_nettype wire

// ==== hdl/vram_controller.sv ====
// vram controller
// round robin over the channels, owns the memory array, muxes register read-back

`default_nettype none
`timescale 1ns/1ps

module vram_controller (
    input  logic                                                        clk,
    input  logic                                                        reset_i,
    input  logic [vram_pkg::NUM_CHAN-1:0]                               req_i,
    input  logic [vram_pkg::NUM_CHAN-1:0]                               we_i,
    input  logic [vram_pkg::NUM_CHAN-1:0][vram_pkg::VRAM_ADDR_W-1:0]    addr_i,
    input  logic [vram_pkg::NUM_CHAN-1:0][bus_pkg::REG_DATA_W-1:0]      wdata_i,
    input  logic [vram_pkg::NUM_CHAN-1:0][3:0][bus_pkg::REG_DATA_W-1:0] chan_reg_words_i,
    input  logic [bus_pkg::REG_NUM_W-1:0]                               reg_num_i,
    output logic [vram_pkg::NUM_CHAN-1:0]                               grant_o,
    output logic [vram_pkg::NUM_CHAN-1:0]                               rdata_valid_o,
    output logic [bus_pkg::REG_DATA_W-1:0]                              rdata_o,
    output logic [bus_pkg::REG_DATA_W-1:0]                              reg_data_o
);
    import bus_pkg::*;
    import vram_pkg::*;

    logic [REG_DATA_W-1:0]  mem [VRAM_DEPTH];
    logic [CHAN_SEL_W-1:0]  last_r;         // last granted, also owner of current grant
    logic [CHAN_SEL_W-1:0]  idx;
    logic [CHAN_SEL_W-1:0]  pick;
    logic                   found;

    // search starts one past the last grant, the channel now granted is masked
    always_comb begin
        pick  = last_r;
        idx   = last_r;
        found = 1'b0;
        for (int k = 1; k <= NUM_CHAN; k++) begin
            idx = last_r + CHAN_SEL_W'(k);
            if (!found && req_i[idx] && !grant_o[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            grant_o       <= '0;
            rdata_valid_o <= '0;
            last_r        <= '0;
        end else begin
            grant_o <= '0;                          // grant lasts one cycle
            if (found) begin
                grant_o[pick] <= 1'b1;
                last_r        <= pick;
            end
            rdata_valid_o <= grant_o & ~we_i;       // read data next cycle
        end
    end

    // access happens in the grant cycle, last_r names the winner
    always_ff @(posedge clk) begin
        if (|grant_o) begin
            if (we_i[last_r]) begin
                mem[addr_i[last_r]] <= wdata_i[last_r];
            end else begin
                rdata_o <= mem[addr_i[last_r]];
            end
        end
    end

    assign reg_data_o = chan_reg_words_i[reg_num_i[REG_NUM_W-1 -: CHAN_SEL_W]][reg_num_i[1:0]];

    a_grant_legal: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(grant_o) && ((grant_o & ~req_i) == '0));

endmodule

`default_nettype wire

// ==== hdl/vram_regs_top.sv ====
// vram register front end
// bus interface, the access channels and the vram controller

`default_nettype none
`timescale 1ns/1ps

module vram_regs_top (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             bus_cs_n_i,
    input  logic                             bus_rd_nwr_i,
    input  logic [bus_pkg::REG_NUM_W-1:0]    bus_reg_num_i,
    input  logic                             bus_bytesel_i,
    input  logic [bus_pkg::BUS_DATA_W-1:0]   bus_data_i,
    output logic [bus_pkg::BUS_DATA_W-1:0]   bus_data_o
);
    import bus_pkg::*;
    import vram_pkg::*;

    logic                                    write_strobe;
    logic                                    read_strobe;
    logic [REG_NUM_W-1:0]                    reg_num;
    logic [REG_DATA_W-1:0]                   wr_word;       // assembled bus word
    logic [REG_DATA_W-1:0]                   rd_word;       // selected register word
    logic [REG_DATA_W-1:0]                   rdata;
    logic [NUM_CHAN-1:0]                     req;
    logic [NUM_CHAN-1:0]                     req_we;
    logic [NUM_CHAN-1:0]                     grant;
    logic [NUM_CHAN-1:0]                     rdata_valid;
    logic [NUM_CHAN-1:0][VRAM_ADDR_W-1:0]    req_addr;
    logic [NUM_CHAN-1:0][REG_DATA_W-1:0]     req_wdata;
    logic [NUM_CHAN-1:0][3:0][REG_DATA_W-1:0] chan_words;

    bus_interface i_bus (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .bus_data_o     (bus_data_o),
        .write_strobe_o (write_strobe),
        .read_strobe_o  (read_strobe),
        .reg_num_o      (reg_num),
        .reg_data_o     (wr_word),
        .reg_data_i     (rd_word)
    );

    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
        vram_channel #(
            .CHAN_ID (c)
        ) i_chan (
            .clk             (clk),
            .reset_i         (reset_i),
            .write_strobe_i  (write_strobe),
            .read_strobe_i   (read_strobe),
            .reg_num_i       (reg_num),
            .reg_data_i      (wr_word),
            .grant_i         (grant[c]),
            .rdata_valid_i   (rdata_valid[c]),
            .rdata_i         (rdata),
            .req_o           (req[c]),
            .req_we_o        (req_we[c]),
            .req_addr_o      (req_addr[c]),
            .req_wdata_o     (req_wdata[c]),
            .chan_reg_word_o (chan_words[c])
        );
    end

    vram_controller i_ctrl (
        .clk              (clk),
        .reset_i          (reset_i),
        .req_i            (req),
        .we_i             (req_we),
        .addr_i           (req_addr),
        .wdata_i          (req_wdata),
        .chan_reg_words_i (chan_words),
        .reg_num_i        (reg_num),
        .grant_o          (grant),
        .rdata_valid_o    (rdata_valid),
        .rdata_o          (rdata),
        .reg_data_o       (rd_word)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_vram_regs.sv ====
// testbench for the vram register front end
// drives the async byte bus and checks register and memory contents against shadow models

`default_nettype none
`timescale 1ns/1ps

module tb_vram_regs;
    import bus_pkg::*;
    import vram_pkg::*;

    localparam logic [31:0] SEED      = 32'h07fd08db;
    localparam int          MAX_POLLS = 16;               // status polls before giving up

    logic       clk;
    logic       reset;
    logic       bus_cs_n;
    logic       bus_rd_nwr;
    logic [3:0] bus_reg_num;
    logic       bus_bytesel;
    logic [7:0] bus_wdata;
    logic [7:0] bus_rdata;

    logic [31:0]            lfsr_state;
    logic [15:0]            sh_mem   [VRAM_DEPTH];        // expected memory
    logic                   sh_valid [VRAM_DEPTH];        // location written at least once
    logic [VRAM_ADDR_W-1:0] sh_addr  [NUM_CHAN];
    logic [15:0]            sh_incr  [NUM_CHAN];
    logic [15:0]            sh_pref  [NUM_CHAN];          // word the channel fetched ahead
    logic                   pref_ok  [NUM_CHAN];

    vram_regs_top i_dut (
        .clk           (clk),
        .reset_i       (reset),
        .bus_cs_n_i    (bus_cs_n),
        .bus_rd_nwr_i  (bus_rd_nwr),
        .bus_reg_num_i (bus_reg_num),
        .bus_bytesel_i (bus_bytesel),
        .bus_data_i    (bus_wdata),
        .bus_data_o    (bus_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                           // 20 ns period
    end

    // galois form with one output bit per step
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [3:0] reg_id(input int c, input logic [1:0] r);
        return {2'(c), r};                                // channel field on top
    endfunction

    // address plus increment modulo the memory depth
    function automatic logic [VRAM_ADDR_W-1:0] advanced_addr(input int c);
        int sum;
        sum = int'(sh_addr[c]) + int'(sh_incr[c]);
        return VRAM_ADDR_W'(sum % VRAM_DEPTH);
    endfunction

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    // one byte access with inputs settled before select and held after it
    task automatic bus_cycle(input logic rd, input logic [3:0] num, input logic bsel,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        bus_rd_nwr  = rd;
        bus_reg_num = num;
        bus_bytesel = bsel;
        bus_wdata   = wdata;
        repeat (3) @(negedge clk);
        bus_cs_n = 1'b0;
        repeat (8) @(negedge clk);                        // read byte settled by now
        rdata    = bus_rdata;
        bus_cs_n = 1'b1;
        repeat (6) @(negedge clk);                        // strobe lands in here
    endtask

    task automatic write16(input logic [3:0] num, input logic [15:0] w);
        logic [7:0] unused_rd;
        bus_cycle(1'b0, num, 1'b0, w[15:8], unused_rd);   // even byte is the high half
        bus_cycle(1'b0, num, 1'b1, w[7:0], unused_rd);
    endtask

    task automatic read16(input logic [3:0] num, output logic [15:0] w);
        logic [7:0] lo;
        logic [7:0] hi;
        bus_cycle(1'b1, num, 1'b0, 8'h00, lo);            // bytesel 0 gives low byte
        bus_cycle(1'b1, num, 1'b1, 8'h00, hi);
        w = {hi, lo};
    endtask

    task automatic wait_idle(input int c);
        logic [7:0] st;
        int         tries;
        st    = 8'hff;
        tries = 0;
        while (st[STATUS_BUSY_BIT] && tries < MAX_POLLS) begin
            bus_cycle(1'b1, reg_id(c, REG_STATUS), 1'b0, 8'h00, st);
            tries++;
        end
        if (st[STATUS_BUSY_BIT]) begin
            $display("channel %0d still busy after %0d status polls", c, tries);
            stop_run();
        end
    endtask

    task automatic fetch_ahead(input int c);
        sh_pref[c] = sh_mem[sh_addr[c]];
        pref_ok[c] = sh_valid[sh_addr[c]];
    endtask

    task automatic set_incr(input int c, input logic [15:0] v);
        write16(reg_id(c, REG_INCR), v);
        sh_incr[c] = v;
    endtask

    task automatic set_addr(input int c, input logic [VRAM_ADDR_W-1:0] a);
        write16(reg_id(c, REG_ADDR), 16'(a));
        sh_addr[c] = a;
        fetch_ahead(c);                                   // address write prefetches
        wait_idle(c);
    endtask

    task automatic data_write(input int c, input logic [15:0] d);
        write16(reg_id(c, REG_DATA), d);
        sh_mem[sh_addr[c]]   = d;
        sh_valid[sh_addr[c]] = 1'b1;
        sh_addr[c]           = advanced_addr(c);
    endtask

    task automatic data_read_check(input int c);
        logic [15:0] w;
        if (!pref_ok[c]) begin
            $display("channel %0d DATA read of a location never written", c);
            stop_run();
        end
        read16(reg_id(c, REG_DATA), w);
        check_word($sformatf("ch%0d DATA", c), w, sh_pref[c]);
        sh_addr[c] = advanced_addr(c);
        fetch_ahead(c);                                   // odd byte read refetches
        wait_idle(c);
    endtask

    task automatic check_addr(input int c);
        logic [15:0] w;
        read16(reg_id(c, REG_ADDR), w);
        check_word($sformatf("ch%0d ADDR", c), w, 16'(sh_addr[c]));
    endtask

    // read byte only moves while the bus is selected
    a_idle_bus_quiet: assert property (@(posedge clk) disable iff (reset)
        bus_cs_n && $past(bus_cs_n, 1) && $past(bus_cs_n, 2) && $past(bus_cs_n, 3)
        |-> $stable(bus_rdata))
        else begin
            $display("bus_data_o changed at %0d ns while chip select was idle", $time);
            stop_run();
        end

    initial begin
        logic [15:0]            word;
        logic [7:0]             lo;
        logic [7:0]             hi;
        logic [7:0]             dummy;
        logic [VRAM_ADDR_W-1:0] start;
        logic [VRAM_ADDR_W-1:0] base [NUM_CHAN];

        lfsr_state  = SEED;
        reset       = 1'b1;
        bus_cs_n    = 1'b1;
        bus_rd_nwr  = 1'b0;
        bus_reg_num = 4'h0;
        bus_bytesel = 1'b0;
        bus_wdata   = 8'h00;
        for (int i = 0; i < VRAM_DEPTH; i++) begin
            sh_valid[i] = 1'b0;
        end
        for (int c = 0; c < NUM_CHAN; c++) begin
            sh_addr[c] = '0;
            sh_incr[c] = '0;
            pref_ok[c] = 1'b0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        // reset state
        check_word("bus_data_o", {8'h00, bus_rdata}, 16'h0000);
        for (int c = 0; c < NUM_CHAN; c++) begin
            read16(reg_id(c, REG_STATUS), word);
            check_word($sformatf("ch%0d STATUS", c), word, 16'h0000);
            check_addr(c);
        end

        // write on ch0 and read back on ch2
        start = VRAM_ADDR_W'(rand_bits(VRAM_ADDR_W));
        set_incr(0, 16'h0001);
        set_addr(0, start);
        data_write(0, rand_bits(16));
        wait_idle(0);
        data_write(0, rand_bits(16));
        wait_idle(0);
        set_incr(2, 16'h0001);
        set_addr(2, start);
        data_read_check(2);
        data_read_check(2);
        check_addr(2);
        check_addr(0);

        // large increment near the top of memory to force a wrap
        start = VRAM_ADDR_W'(VRAM_DEPTH - 3);
        set_incr(1, rand_bits(16) | 16'h0200);
        set_addr(1, start);
        for (int k = 0; k < 6; k++) begin
            data_write(1, rand_bits(16));
            wait_idle(1);
            check_addr(1);
        end
        set_addr(1, start);
        for (int k = 0; k < 6; k++) begin
            data_read_check(1);
        end

        // all channels interleaved without waits between writes
        for (int c = 0; c < NUM_CHAN; c++) begin
            base[c] = VRAM_ADDR_W'(rand_bits(VRAM_ADDR_W));
            set_incr(c, 16'h0001);
            set_addr(c, base[c]);
        end
        for (int k = 0; k < 4; k++) begin
            for (int c = 0; c < NUM_CHAN; c++) begin
                data_write(c, rand_bits(16));
            end
        end
        for (int c = 0; c < NUM_CHAN; c++) begin
            wait_idle(c);
            read16(reg_id(c, REG_STATUS), word);          // drop must be clear
            check_word($sformatf("ch%0d STATUS", c), word, 16'h0000);
        end
        for (int c = 0; c < NUM_CHAN; c++) begin
            set_addr(c, base[c]);
            for (int k = 0; k < 4; k++) begin
                data_read_check(c);
            end
        end

        // odd byte to another register than the buffered even byte
        bus_cycle(1'b0, reg_id(3, REG_ADDR), 1'b0, 8'h5a, dummy);
        lo = 8'(rand_bits(8));
        bus_cycle(1'b0, reg_id(3, REG_INCR), 1'b1, lo, dummy);
        sh_incr[3] = {8'h00, lo};                         // high byte dropped to zero
        read16(reg_id(3, REG_INCR), word);
        check_word("ch3 INCR", word, sh_incr[3]);

        // byte lanes of a read and then busy clear when idle
        word = rand_bits(16);
        set_incr(2, word);
        bus_cycle(1'b1, reg_id(2, REG_INCR), 1'b0, 8'h00, lo);
        check_word("bus_data_o even byte of ch2 INCR", {8'h00, lo}, {8'h00, word[7:0]});
        bus_cycle(1'b1, reg_id(2, REG_INCR), 1'b1, 8'h00, hi);
        check_word("bus_data_o odd byte of ch2 INCR", {8'h00, hi}, {8'h00, word[15:8]});
        for (int c = 0; c < NUM_CHAN; c++) begin
            read16(reg_id(c, REG_STATUS), word);
            check_word($sformatf("ch%0d STATUS busy", c), 16'(word[STATUS_BUSY_BIT]),
                       16'h0000);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/bus_pkg.sv
hdl/vram_pkg.sv
hdl/bus_interface.sv
hdl/vram_channel.sv
hdl/vram_controller.sv
hdl/vram_regs_top.sv
testbench/tb_vram_regs.sv

// ==== Makefile ====
# Verilator build for the vram register front end testbench

SIM      = verilator
TOP      = tb_vram_regs
FILELIST = filelist.f
FLAGS    = --binary --timing --assert --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
